// File: logic/mips_pkg.sv
package mips_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B,
		OP_HALT  = 6'h3F
	} opcode_e;

	// ALU_ADD must stay zero so a bubble decodes as a harmless add
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	localparam logic [5:0] FUNCT_ADD = 6'h20;
	localparam logic [5:0] FUNCT_SUB = 6'h22;
	localparam logic [5:0] FUNCT_AND = 6'h24;
	localparam logic [5:0] FUNCT_OR  = 6'h25;
	localparam logic [5:0] FUNCT_SLT = 6'h2A;

	// Word address, not byte address
	typedef struct packed {
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] next_pc;
	} if_id_t;

	typedef struct packed {
		logic [31:0] next_pc;
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic [31:0] imm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic        reg_write;
		logic        memto_reg;
		logic        mem_write;
		logic        mem_read;
		logic        reg_dst;
		alu_op_e     alu_op;
		logic        alu_src;
		logic        branch;
		logic        halt;
	} id_ex_t;

	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0]  dest;
		logic        reg_write;
		logic        memto_reg;
		logic        mem_read;
		logic        mem_write;
		logic        halt;
	} ex_mem_t;

	typedef struct packed {
		logic [31:0] wb_value;
		logic [4:0]  dest;
		logic        reg_write;
		logic        halt;
	} mem_wb_t;

endpackage

// File: logic/pipe_latch.sv
`timescale 1ns/10ps

module pipe_latch
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     ena,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Flush only acts together with enable, so a frozen stage keeps its content
	always_ff @(posedge clk)
	begin
		if (reset)
			q <= '0;
		else if (ena)
		begin
			if (flush)
				q <= '0;
			else
				q <= d;
		end
	end

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file
#(
	parameter int DATA_W = 32,
	parameter int REG_W  = 5
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic [REG_W-1:0]  rs_addr,
	input  logic [REG_W-1:0]  rt_addr,
	output logic [DATA_W-1:0] rs_data,
	output logic [DATA_W-1:0] rt_data,
	input  logic              wr_en,
	input  logic [REG_W-1:0]  wr_addr,
	input  logic [DATA_W-1:0] wr_data
);

	logic [DATA_W-1:0] regs [2**REG_W];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**REG_W; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

	// Write-through so decode sees the write-back value in the same cycle
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wr_en && wr_addr == addr)
			return wr_data;
		return regs[addr];
	endfunction

	always_comb
	begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
	import mips_pkg::*;
#(
	parameter int DATA_W = 32
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              hold,
	input  logic              redirect,
	input  logic [DATA_W-1:0] target,
	output logic              fetch_valid,
	input  logic              fetch_ready,
	output mem_req_t          fetch_req,
	input  logic [DATA_W-1:0] fetch_rdata,
	output if_id_t            if_id,
	output logic              bubble
);

	// Byte address
	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] pc_plus4;
	logic              running;

	assign pc_plus4 = pc + DATA_W'(4);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			running <= 1'b0;
		end
		else
		begin
			running <= 1'b1;
			if (redirect)
				pc <= target;
			else if (fetch_ready && !hold)
				pc <= pc_plus4;
		end
	end

	// No request on redirect, the old pc is on the wrong path
	assign fetch_valid = running & ~redirect;

	always_comb
	begin
		fetch_req = '0;
		fetch_req.addr = {2'b00, pc[DATA_W-1:2]};
	end

	assign if_id.instr = fetch_rdata;
	assign if_id.next_pc = pc_plus4;
	assign bubble = ~fetch_ready;

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
	import mips_pkg::*;
#(
	parameter int DATA_W = 32,
	parameter int REG_W  = 5
)
(
	input  logic    clk,
	input  logic    reset,
	input  if_id_t  if_id,
	input  id_ex_t  id_ex_now,
	input  ex_mem_t ex_mem_now,
	input  mem_wb_t mem_wb_now,
	output id_ex_t  id_ex,
	output logic    hazard_stall,
	output logic    halt_hold
);

	logic [5:0]        opcode;
	logic [5:0]        funct;
	logic [REG_W-1:0]  rs;
	logic [REG_W-1:0]  rt;
	logic [REG_W-1:0]  rd;
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] rt_data;
	logic [REG_W-1:0]  id_ex_dest;
	logic              uses_rs;
	logic              uses_rt;
	logic              rs_busy;
	logic              rt_busy;
	logic              r_known;
	alu_op_e           r_op;
	logic              halt_seen;
	id_ex_t            ctrl;

	assign opcode = if_id.instr[31:26];
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];
	assign funct = if_id.instr[5:0];

	register_file #(.DATA_W(DATA_W), .REG_W(REG_W)) u_regs (
		.clk(clk),
		.reset(reset),
		.rs_addr(rs),
		.rt_addr(rt),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wr_en(mem_wb_now.reg_write),
		.wr_addr(mem_wb_now.dest),
		.wr_data(mem_wb_now.wb_value)
	);

	always_comb
	begin
		r_known = 1'b1;
		case (funct)
			FUNCT_ADD: r_op = ALU_ADD;
			FUNCT_SUB: r_op = ALU_SUB;
			FUNCT_AND: r_op = ALU_AND;
			FUNCT_OR:  r_op = ALU_OR;
			FUNCT_SLT: r_op = ALU_SLT;
			default:
			begin
				r_op = ALU_ADD;
				r_known = 1'b0;
			end
		endcase
	end

	// Unknown encodings fall through as no-ops
	always_comb
	begin
		ctrl = '0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			OP_RTYPE:
			begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				ctrl.reg_write = r_known;
				ctrl.reg_dst = r_known;
				ctrl.alu_op = r_op;
			end
			OP_ADDI:
			begin
				uses_rs = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
			end
			OP_LW:
			begin
				uses_rs = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.memto_reg = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.alu_src = 1'b1;
			end
			OP_SW:
			begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_src = 1'b1;
			end
			OP_BEQ:
			begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_HALT:
				ctrl.halt = 1'b1;
			default:
				ctrl = '0;
		endcase
	end

	always_comb
	begin
		id_ex = ctrl;
		id_ex.next_pc = if_id.next_pc;
		id_ex.rd1 = rs_data;
		id_ex.rd2 = rt_data;
		id_ex.imm = {{(DATA_W-16){if_id.instr[15]}}, if_id.instr[15:0]};
		id_ex.rs = rs;
		id_ex.rt = rt;
		id_ex.rd = rd;
	end

	// RAW check against every stage still ahead of write-back
	function automatic logic dest_match(
		input logic [REG_W-1:0] src,
		input logic [REG_W-1:0] dest,
		input logic             wr
	);
		return wr && src != '0 && src == dest;
	endfunction

	assign id_ex_dest = id_ex_now.reg_dst ? id_ex_now.rd : id_ex_now.rt;

	assign rs_busy = dest_match(rs, id_ex_dest, id_ex_now.reg_write)
		|| dest_match(rs, ex_mem_now.dest, ex_mem_now.reg_write)
		|| dest_match(rs, mem_wb_now.dest, mem_wb_now.reg_write);
	assign rt_busy = dest_match(rt, id_ex_dest, id_ex_now.reg_write)
		|| dest_match(rt, ex_mem_now.dest, ex_mem_now.reg_write)
		|| dest_match(rt, mem_wb_now.dest, mem_wb_now.reg_write);

	assign hazard_stall = (uses_rs && rs_busy) || (uses_rt && rt_busy);

	// Once HALT commits nothing more is fetched until reset
	always_ff @(posedge clk)
	begin
		if (reset)
			halt_seen <= 1'b0;
		else if (mem_wb_now.halt)
			halt_seen <= 1'b1;
	end

	assign halt_hold = (opcode == OP_HALT) | id_ex_now.halt | ex_mem_now.halt
		| mem_wb_now.halt | halt_seen;

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
	import mips_pkg::*;
#(
	parameter int DATA_W = 32
)
(
	input  id_ex_t            id_ex,
	output ex_mem_t           ex_mem,
	output logic              branch_taken,
	output logic [DATA_W-1:0] branch_target
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] result;

	assign op_a = id_ex.rd1;
	assign op_b = id_ex.alu_src ? id_ex.imm : id_ex.rd2;

	always_comb
	begin
		case (id_ex.alu_op)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_SLT: result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	// BEQ runs a subtract, equal operands give zero
	assign branch_taken = id_ex.branch && result == '0;
	assign branch_target = id_ex.next_pc + {id_ex.imm[DATA_W-3:0], 2'b00};

	always_comb
	begin
		ex_mem.alu_result = result;
		ex_mem.store_data = id_ex.rd2;
		ex_mem.dest = id_ex.reg_dst ? id_ex.rd : id_ex.rt;
		ex_mem.reg_write = id_ex.reg_write;
		ex_mem.memto_reg = id_ex.memto_reg;
		ex_mem.mem_read = id_ex.mem_read;
		ex_mem.mem_write = id_ex.mem_write;
		ex_mem.halt = id_ex.halt;
	end

endmodule

// File: logic/mem_access_unit.sv
`timescale 1ns/10ps

module mem_access_unit
	import mips_pkg::*;
(
	input  ex_mem_t     ex_mem,
	output logic        data_valid,
	input  logic        data_ready,
	output mem_req_t    data_req,
	input  logic [31:0] data_rdata,
	output mem_wb_t     mem_wb,
	output logic        freeze
);

	assign data_valid = ex_mem.mem_read | ex_mem.mem_write;

	// ALU result is a byte address
	assign data_req.we = ex_mem.mem_write;
	assign data_req.addr = {2'b00, ex_mem.alu_result[31:2]};
	assign data_req.wdata = ex_mem.store_data;

	// Whole pipeline waits for the data port
	assign freeze = data_valid & ~data_ready;

	assign mem_wb.wb_value = ex_mem.memto_reg ? data_rdata : ex_mem.alu_result;
	assign mem_wb.dest = ex_mem.dest;
	assign mem_wb.reg_write = ex_mem.reg_write;
	assign mem_wb.halt = ex_mem.halt;

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
	import mips_pkg::*;
(
	input  logic        ext_valid,
	output logic        ext_ready,
	input  mem_req_t    ext_req,
	output logic [31:0] ext_rdata,
	input  logic        data_valid,
	output logic        data_ready,
	input  mem_req_t    data_req,
	output logic [31:0] data_rdata,
	input  logic        fetch_valid,
	output logic        fetch_ready,
	input  mem_req_t    fetch_req,
	output logic [31:0] fetch_rdata,
	output logic        mem_en,
	output mem_req_t    mem_req,
	input  logic [31:0] mem_rdata
);

	// Fixed priority: external, data, fetch
	assign ext_ready = ext_valid;
	assign data_ready = data_valid & ~ext_valid;
	assign fetch_ready = fetch_valid & ~ext_valid & ~data_valid;

	assign mem_en = ext_valid | data_valid | fetch_valid;

	always_comb
	begin
		if (ext_valid)
			mem_req = ext_req;
		else if (data_valid)
			mem_req = data_req;
		else
			mem_req = fetch_req;
	end

	// Only the granted master samples it
	assign ext_rdata = mem_rdata;
	assign data_rdata = mem_rdata;
	assign fetch_rdata = mem_rdata;

endmodule

// File: logic/unified_memory.sv
`timescale 1ns/10ps

module unified_memory
	import mips_pkg::*;
#(
	parameter int MEM_WORDS = 256
)
(
	input  logic        clk,
	input  logic        mem_en,
	input  mem_req_t    mem_req,
	output logic [31:0] mem_rdata
);

	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0]   mem [MEM_WORDS];
	logic [AW-1:0] index;

	assign index = mem_req.addr[AW-1:0];
	assign mem_rdata = mem[index];

	always_ff @(posedge clk)
	begin
		if (mem_en && mem_req.we)
			mem[index] <= mem_req.wdata;
	end

endmodule

// File: logic/mips_core_top.sv
`timescale 1ns/10ps

module mips_core_top
	import mips_pkg::*;
#(
	parameter int DATA_W    = 32,
	parameter int REG_W     = 5,
	parameter int MEM_WORDS = 256
)
(
	input  logic              clk,
	input  logic              reset,
	input  logic              ext_valid,
	output logic              ext_ready,
	input  mem_req_t          ext_req,
	output logic [DATA_W-1:0] ext_rdata,
	output logic              halted
);

	if_id_t            if_id_d;
	if_id_t            if_id_q;
	id_ex_t            id_ex_d;
	id_ex_t            id_ex_q;
	ex_mem_t           ex_mem_d;
	ex_mem_t           ex_mem_q;
	mem_wb_t           mem_wb_d;
	mem_wb_t           mem_wb_q;
	logic              fetch_valid;
	logic              fetch_ready;
	mem_req_t          fetch_req;
	logic [DATA_W-1:0] fetch_rdata;
	logic              data_valid;
	logic              data_ready;
	mem_req_t          data_req;
	logic [DATA_W-1:0] data_rdata;
	logic              mem_en;
	mem_req_t          mem_req;
	logic [DATA_W-1:0] mem_rdata;
	logic              fetch_bubble;
	logic              hazard_stall;
	logic              halt_hold;
	logic              freeze;
	logic              branch_taken;
	logic [DATA_W-1:0] branch_target;
	logic              redirect;
	logic              fetch_hold;
	logic              if_id_ena;
	logic              if_id_flush;

	// A branch held by freeze resolves once the pipeline moves again
	assign redirect = branch_taken & ~freeze;
	assign fetch_hold = freeze | hazard_stall | halt_hold;
	assign if_id_ena = ~freeze & (~hazard_stall | redirect);
	assign if_id_flush = fetch_bubble | redirect | halt_hold;

	fetch_unit #(.DATA_W(DATA_W)) u_fetch (
		.clk(clk),
		.reset(reset),
		.hold(fetch_hold),
		.redirect(redirect),
		.target(branch_target),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch_req(fetch_req),
		.fetch_rdata(fetch_rdata),
		.if_id(if_id_d),
		.bubble(fetch_bubble)
	);

	pipe_latch #(.payload_t(if_id_t)) u_if_id (
		.clk(clk),
		.reset(reset),
		.ena(if_id_ena),
		.flush(if_id_flush),
		.d(if_id_d),
		.q(if_id_q)
	);

	decode_stage #(.DATA_W(DATA_W), .REG_W(REG_W)) u_decode (
		.clk(clk),
		.reset(reset),
		.if_id(if_id_q),
		.id_ex_now(id_ex_q),
		.ex_mem_now(ex_mem_q),
		.mem_wb_now(mem_wb_q),
		.id_ex(id_ex_d),
		.hazard_stall(hazard_stall),
		.halt_hold(halt_hold)
	);

	pipe_latch #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.reset(reset),
		.ena(~freeze),
		.flush(hazard_stall | redirect),
		.d(id_ex_d),
		.q(id_ex_q)
	);

	execute_stage #(.DATA_W(DATA_W)) u_execute (
		.id_ex(id_ex_q),
		.ex_mem(ex_mem_d),
		.branch_taken(branch_taken),
		.branch_target(branch_target)
	);

	pipe_latch #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk),
		.reset(reset),
		.ena(~freeze),
		.flush(1'b0),
		.d(ex_mem_d),
		.q(ex_mem_q)
	);

	mem_access_unit u_mem_access (
		.ex_mem(ex_mem_q),
		.data_valid(data_valid),
		.data_ready(data_ready),
		.data_req(data_req),
		.data_rdata(data_rdata),
		.mem_wb(mem_wb_d),
		.freeze(freeze)
	);

	pipe_latch #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk),
		.reset(reset),
		.ena(~freeze),
		.flush(1'b0),
		.d(mem_wb_d),
		.q(mem_wb_q)
	);

	mem_arbiter u_arbiter (
		.ext_valid(ext_valid),
		.ext_ready(ext_ready),
		.ext_req(ext_req),
		.ext_rdata(ext_rdata),
		.data_valid(data_valid),
		.data_ready(data_ready),
		.data_req(data_req),
		.data_rdata(data_rdata),
		.fetch_valid(fetch_valid),
		.fetch_ready(fetch_ready),
		.fetch_req(fetch_req),
		.fetch_rdata(fetch_rdata),
		.mem_en(mem_en),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata)
	);

	unified_memory #(.MEM_WORDS(MEM_WORDS)) u_memory (
		.clk(clk),
		.mem_en(mem_en),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			halted <= 1'b0;
		else if (mem_wb_q.halt)
			halted <= 1'b1;
	end

endmodule

// File: verification/mips_core_sva.sv
`timescale 1ns/10ps

module mips_core_sva
	import mips_pkg::*;
(
	input logic     clk,
	input logic     reset,
	input logic     ext_valid,
	input logic     ext_ready,
	input mem_req_t ext_req,
	input logic     data_valid,
	input logic     data_ready,
	input mem_req_t data_req,
	input logic     fetch_valid,
	input logic     fetch_ready,
	input mem_req_t fetch_req
);

	// Single memory port
	grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({ext_ready, data_ready, fetch_ready}))
		else $error("more than one memory master granted");

	grant_needs_valid: assert property (@(posedge clk) disable iff (reset)
		(!ext_ready || ext_valid) && (!data_ready || data_valid)
		&& (!fetch_ready || fetch_valid))
		else $error("ready given to a master without valid");

	// Waiting masters hold their request
	ext_req_stable: assert property (@(posedge clk) disable iff (reset)
		ext_valid && !ext_ready |=> $stable(ext_req))
		else $error("external request changed while waiting");

	data_req_stable: assert property (@(posedge clk) disable iff (reset)
		data_valid && !data_ready |=> $stable(data_req))
		else $error("data request changed while waiting");

	fetch_req_stable: assert property (@(posedge clk) disable iff (reset)
		fetch_valid && !fetch_ready |=> $stable(fetch_req))
		else $error("fetch request changed while waiting");

endmodule

bind mips_core_top mips_core_sva u_sva (
	.clk(clk),
	.reset(reset),
	.ext_valid(ext_valid),
	.ext_ready(ext_ready),
	.ext_req(ext_req),
	.data_valid(data_valid),
	.data_ready(data_ready),
	.data_req(data_req),
	.fetch_valid(fetch_valid),
	.fetch_ready(fetch_ready),
	.fetch_req(fetch_req)
);

// File: verification/mips_core_tb.sv
`timescale 1ns/10ps

module mips_core_tb
	import mips_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int MEM_WORDS    = 256;
	localparam int NUM_TESTS    = 5;
	localparam int MAX_PROG     = 16;
	localparam int MAX_RES      = 5;
	localparam int RUN_LIMIT    = 200;
	localparam int HOLD_CYCLES  = 8;
	// Reset, full memory load, run to halt, hold check and readback
	localparam int TEST_CYCLES  = RESET_CYCLES + MEM_WORDS + RUN_LIMIT + HOLD_CYCLES
		+ 2 * MAX_RES + 16;
	localparam int WATCHDOG_NS  = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

	logic        clk;
	logic        reset;
	logic        ext_valid;
	logic        ext_ready;
	mem_req_t    ext_req;
	logic [31:0] ext_rdata;
	logic        halted;

	logic [31:0] prog_words [NUM_TESTS][MAX_PROG];
	int          prog_len [NUM_TESTS];
	int          res_addr [NUM_TESTS];
	int          res_count [NUM_TESTS];
	logic [31:0] res_expect [NUM_TESTS][MAX_RES];
	string       test_name [NUM_TESTS];
	int          failed_tests;
	int          total_errors;

	mips_core_top #(.DATA_W(32), .REG_W(5), .MEM_WORDS(MEM_WORDS)) UUT (
		.clk(clk),
		.reset(reset),
		.ext_valid(ext_valid),
		.ext_ready(ext_ready),
		.ext_req(ext_req),
		.ext_rdata(ext_rdata),
		.halted(halted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Background value of every word that no program writes
	function automatic logic [31:0] fill_word(input int addr);
		return 32'hFEED_0000 ^ addr;
	endfunction

	function automatic logic [31:0] sext(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic [15:0] word_offset(input int word);
		int b;
		b = word * 4;
		return b[15:0];
	endfunction

	function automatic logic [31:0] r_instr(input logic [5:0] funct, input int rd,
		input int rs, input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic logic [31:0] i_instr(input logic [5:0] op, input int rt,
		input int rs, input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] halt_instr();
		return {OP_HALT, 26'd0};
	endfunction

	task automatic add_word(input int t, input logic [31:0] w);
		prog_words[t][prog_len[t]] = w;
		prog_len[t]++;
	endtask

	task automatic add_expect(input int t, input logic [31:0] v);
		res_expect[t][res_count[t]] = v;
		res_count[t]++;
	endtask

	task automatic build_table();
		logic [15:0] ia;
		logic [15:0] ib;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] v3;
		logic [31:0] v4;
		logic [31:0] v5;
		logic [31:0] v6;
		logic [31:0] v7;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			prog_len[t] = 0;
			res_count[t] = 0;
		end

		// Dependent ALU chain where each op reads the one before
		test_name[0] = "arithmetic and logic";
		res_addr[0] = 128;
		ia = 16'($urandom());
		ib = 16'($urandom());
		va = sext(ia);
		vb = sext(ib);
		v3 = va + vb;
		v4 = vb - v3;
		v5 = v4 & v3;
		v6 = v5 | va;
		v7 = ($signed(v6) < $signed(vb)) ? 32'd1 : 32'd0;
		add_word(0, i_instr(OP_ADDI, 1, 0, ia));
		add_word(0, i_instr(OP_ADDI, 2, 0, ib));
		add_word(0, r_instr(FUNCT_ADD, 3, 1, 2));
		add_word(0, r_instr(FUNCT_SUB, 4, 2, 3));
		add_word(0, r_instr(FUNCT_AND, 5, 4, 3));
		add_word(0, r_instr(FUNCT_OR, 6, 5, 1));
		add_word(0, r_instr(FUNCT_SLT, 7, 6, 2));
		for (int r = 3; r <= 7; r++)
			add_word(0, i_instr(OP_SW, r, 0, word_offset(res_addr[0] + r - 3)));
		add_word(0, halt_instr());
		add_expect(0, v3);
		add_expect(0, v4);
		add_expect(0, v5);
		add_expect(0, v6);
		add_expect(0, v7);

		test_name[1] = "load-use";
		res_addr[1] = 136;
		ia = 16'($urandom());
		ib = 16'($urandom());
		add_word(1, i_instr(OP_ADDI, 1, 0, ia));
		add_word(1, i_instr(OP_ADDI, 2, 0, ib));
		add_word(1, i_instr(OP_SW, 1, 0, word_offset(res_addr[1])));
		add_word(1, i_instr(OP_LW, 3, 0, word_offset(res_addr[1])));
		add_word(1, r_instr(FUNCT_ADD, 4, 3, 2));
		add_word(1, i_instr(OP_SW, 4, 0, word_offset(res_addr[1] + 1)));
		add_word(1, halt_instr());
		add_expect(1, sext(ia));
		add_expect(1, sext(ia) + sext(ib));

		// Taken BEQ skips two stores and the not-taken one falls through
		test_name[2] = "branch";
		res_addr[2] = 144;
		ia = 16'($urandom()) | 16'h0001;
		add_word(2, i_instr(OP_ADDI, 1, 0, ia));
		add_word(2, i_instr(OP_ADDI, 2, 0, ia));
		add_word(2, i_instr(OP_BEQ, 2, 1, 16'd2));
		add_word(2, i_instr(OP_SW, 1, 0, word_offset(res_addr[2])));
		add_word(2, i_instr(OP_SW, 1, 0, word_offset(res_addr[2] + 1)));
		add_word(2, i_instr(OP_BEQ, 0, 1, 16'd1));
		add_word(2, i_instr(OP_SW, 2, 0, word_offset(res_addr[2] + 2)));
		add_word(2, i_instr(OP_SW, 1, 0, word_offset(res_addr[2] + 3)));
		add_word(2, halt_instr());
		add_expect(2, fill_word(res_addr[2]));
		add_expect(2, fill_word(res_addr[2] + 1));
		add_expect(2, sext(ia));
		add_expect(2, sext(ia));

		test_name[3] = "memory contention";
		res_addr[3] = 152;
		for (int k = 0; k < 4; k++)
		begin
			add_word(3, i_instr(OP_LW, k + 1, 0, word_offset(200 + k)));
			add_word(3, i_instr(OP_SW, k + 1, 0, word_offset(res_addr[3] + k)));
			add_expect(3, fill_word(200 + k));
		end
		add_word(3, halt_instr());

		test_name[4] = "halt";
		res_addr[4] = 168;
		ia = 16'($urandom());
		add_word(4, i_instr(OP_ADDI, 1, 0, ia));
		add_word(4, i_instr(OP_SW, 1, 0, word_offset(res_addr[4])));
		add_word(4, halt_instr());
		add_word(4, i_instr(OP_SW, 1, 0, word_offset(res_addr[4] + 1)));
		add_word(4, i_instr(OP_SW, 1, 0, word_offset(res_addr[4] + 2)));
		add_expect(4, sext(ia));
		add_expect(4, fill_word(res_addr[4] + 1));
		add_expect(4, fill_word(res_addr[4] + 2));
	endtask

	task automatic read_word(input int addr, output logic [31:0] data,
		output logic granted);
		ext_valid = 1'b1;
		ext_req.we = 1'b0;
		ext_req.addr = addr;
		ext_req.wdata = '0;
		@(posedge clk);
		data = ext_rdata;
		granted = ext_ready;
		@(negedge clk);
		ext_valid = 1'b0;
	endtask

	task automatic run_test(input int t);
		int          cycles;
		int          errors;
		logic [31:0] got;
		logic        granted;
		errors = 0;
		cycles = 0;
		@(negedge clk);
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		// Whole memory rewritten so each program starts from the same image
		for (int a = 0; a < MEM_WORDS; a++)
		begin
			ext_valid = 1'b1;
			ext_req.we = 1'b1;
			ext_req.addr = a;
			ext_req.wdata = (a < prog_len[t]) ? prog_words[t][a] : fill_word(a);
			@(negedge clk);
		end
		ext_valid = 1'b0;
		ext_req = '0;
		reset = 1'b0;
		@(negedge clk);
		if (halted)
		begin
			$display("Test %0d: halted is high right after reset", t);
			errors++;
		end
		while (!halted && cycles < RUN_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
		begin
			$display("Test %0d: core did not halt within %0d cycles", t, RUN_LIMIT);
			errors++;
		end
		else
		begin
			repeat (HOLD_CYCLES) @(negedge clk);
			if (!halted)
			begin
				$display("Test %0d: halted dropped after it was set", t);
				errors++;
			end
			for (int k = 0; k < res_count[t]; k++)
			begin
				read_word(res_addr[t] + k, got, granted);
				if (granted !== 1'b1)
				begin
					$display("** Error: test %0d ext_ready at word %0d = 0x%h, expected 0x1",
						t, res_addr[t] + k, granted);
					errors++;
				end
				if (got !== res_expect[t][k])
				begin
					$display("** Error: test %0d ext_rdata at word %0d = 0x%h, expected 0x%h",
						t, res_addr[t] + k, got, res_expect[t][k]);
					errors++;
				end
			end
		end
		$display("Test %0d (%s): %s, halted after %0d cycles", t, test_name[t],
			(errors == 0) ? "ok" : "FAILED", cycles);
		if (errors != 0)
			failed_tests++;
		total_errors += errors;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		ext_valid = 1'b0;
		ext_req = '0;
		failed_tests = 0;
		total_errors = 0;
		void'($urandom(22033));
		build_table();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS,
			NUM_TESTS - failed_tests, failed_tests, total_errors);
		if (failed_tests == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: src.f
logic/mips_pkg.sv
logic/pipe_latch.sv
logic/register_file.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_access_unit.sv
logic/mem_arbiter.sv
logic/unified_memory.sv
logic/mips_core_top.sv
verification/mips_core_sva.sv
verification/mips_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mips_core_tb \
	-f src.f -o mips_core_sim

output=$(./obj_dir/mips_core_sim 2>&1) || true
echo "$output"

if grep -qF -- "*** TEST PASSED ***" <<< "$output"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
